// File: arm_decode_pkg.sv
package arm_decode_pkg;

	typedef logic [31:0] word;
	typedef logic [3:0] reg_num;
	typedef logic [3:0] alu_op;
	typedef logic [3:0] psr_flags; // n z c v
	typedef logic [3:0] msr_mask;

	localparam alu_op alu_and = 4'h0;
	localparam alu_op alu_eor = 4'h1;
	localparam alu_op alu_sub = 4'h2;
	localparam alu_op alu_rsb = 4'h3;
	localparam alu_op alu_add = 4'h4;
	localparam alu_op alu_adc = 4'h5;
	localparam alu_op alu_sbc = 4'h6;
	localparam alu_op alu_rsc = 4'h7;
	localparam alu_op alu_tst = 4'h8;
	localparam alu_op alu_teq = 4'h9;
	localparam alu_op alu_cmp = 4'ha;
	localparam alu_op alu_cmn = 4'hb;
	localparam alu_op alu_orr = 4'hc;
	localparam alu_op alu_mov = 4'hd;
	localparam alu_op alu_bic = 4'he;
	localparam alu_op alu_mvn = 4'hf;

	localparam reg_num r14 = 4'd14;
	localparam reg_num r15 = 4'd15;

	// shift kind: lsl 00, lsr shr, asr shr+ror, ror ror
	typedef struct packed {
		reg_num      r;
		logic [11:0] imm;
		logic        is_imm;
		logic [4:0]  shift_imm;
		logic        shr;
		logic        ror;
		logic        shift_by_reg; // rs sits in imm[3:0]
	} snd_decode;

	typedef struct packed {
		alu_op  op;
		reg_num rd;
		reg_num rn;
		logic   uses_rn;
	} data_decode;

	typedef struct packed {
		logic        load;
		logic        writeback;
		logic        pre_index;
		logic        increment;
		logic [1:0]  size; // 00 byte, 01 half, 10 word
		logic        sign_extend;
		logic        user_mode;
		logic [15:0] reg_list;
	} ldst_decode;

	typedef struct packed {
		logic   load;
		reg_num cp_num;
	} coproc_decode;

	typedef struct packed {
		word        insn;
		data_decode data;
		snd_decode  snd;
		ldst_decode ldst;
		ldst_decode ldst_addr;
		logic       execute;
		logic       undefined;
		logic       conditional;
		logic       writeback;
		logic       update_flags;
		logic       branch;
		logic       ldst_op;
		logic       mul;
		logic       coproc;
		logic       spsr;
		logic       psr_write;
		logic       restore_spsr;
	} decoded_insn;

	// pattern and mask over insn[27:4]
	typedef struct packed {
		logic [23:0] bits;
		logic [23:0] mask;
	} op_group;

	localparam op_group grp_b           = '{bits: 24'ha00000, mask: 24'he00000};
	localparam op_group grp_mul         = '{bits: 24'h000009, mask: 24'hfc000f};
	localparam op_group grp_alu         = '{bits: 24'h000000, mask: 24'hc00000};
	localparam op_group grp_ldst_single = '{bits: 24'h400000, mask: 24'hc00000};
	localparam op_group grp_ldst_misc   = '{bits: 24'h000009, mask: 24'he00009};
	localparam op_group grp_ldst_mult   = '{bits: 24'h800000, mask: 24'he00000};
	localparam op_group grp_cp          = '{bits: 24'he00001, mask: 24'hf00001};
	localparam op_group grp_mrs         = '{bits: 24'h100000, mask: 24'hfb000f};
	localparam op_group grp_msr         = '{bits: 24'h120000, mask: 24'hdb0000};

	function automatic logic grp_match(word insn, op_group grp);
		return (insn[27:4] & grp.mask) == grp.bits;
	endfunction

	// register operand with an immediate shift amount
	function automatic snd_decode snd_reg_form(word insn);
		snd_decode s;
		s = '0;
		s.r = insn[3:0];
		s.shift_imm = insn[11:7];
		s.shr = ^insn[6:5];
		s.ror = insn[6];
		return s;
	endfunction

endpackage

// File: decode_cond.sv
`timescale 1ns/1ps

module decode_cond (
	input  arm_decode_pkg::word      insn,
	input  arm_decode_pkg::psr_flags flags,
	output logic                     cond_execute,
	output logic                     cond_undefined,
	output logic                     explicit_cond
);

	logic n, z, c, v;

	assign {n, z, c, v} = flags;
	assign explicit_cond = insn[31:28] != 4'he;

	always_comb begin
		cond_undefined = 1'b0;
		unique case (insn[31:28])
			4'h0: cond_execute = z; // eq
			4'h1: cond_execute = !z;
			4'h2: cond_execute = c; // cs
			4'h3: cond_execute = !c;
			4'h4: cond_execute = n; // mi
			4'h5: cond_execute = !n;
			4'h6: cond_execute = v; // vs
			4'h7: cond_execute = !v;
			4'h8: cond_execute = c && !z; // hi
			4'h9: cond_execute = !c || z;
			4'ha: cond_execute = n == v; // ge
			4'hb: cond_execute = n != v;
			4'hc: cond_execute = !z && (n == v); // gt
			4'hd: cond_execute = z || (n != v);
			4'he: cond_execute = 1'b1;
			default: begin
				cond_execute = 1'b0; // nv space
				cond_undefined = 1'b1;
			end
		endcase
	end

endmodule

// File: decode_data.sv
`timescale 1ns/1ps

module decode_data (
	input  arm_decode_pkg::word        insn,
	output arm_decode_pkg::data_decode data,
	output arm_decode_pkg::snd_decode  snd,
	output logic                       snd_undefined,
	                                   data_writeback,
	                                   data_conditional,
	                                   data_update_flags,
	                                   data_restore_spsr,
	                                   data_is_imm,
	                                   data_shift_by_reg_if_reg
);

	arm_decode_pkg::alu_op op;
	logic s_bit;
	logic is_cmp;

	assign op = insn[24:21];
	assign s_bit = insn[20];
	assign is_cmp = op[3:2] == 2'b10; // tst teq cmp cmn

	assign data_is_imm = insn[25];
	assign data_shift_by_reg_if_reg = insn[4];

	always_comb begin
		data.op = op;
		data.rd = insn[15:12];
		data.rn = insn[19:16];
		data.uses_rn = op != arm_decode_pkg::alu_mov && op != arm_decode_pkg::alu_mvn;
	end

	assign data_writeback = !is_cmp;
	assign data_update_flags = s_bit || is_cmp;
	assign data_restore_spsr = s_bit && !is_cmp && insn[15:12] == arm_decode_pkg::r15;

	// carry in feeds the result
	assign data_conditional = op == arm_decode_pkg::alu_adc || op == arm_decode_pkg::alu_sbc
		|| op == arm_decode_pkg::alu_rsc;

	always_comb begin
		if (data_is_imm) begin
			snd = '0;
			snd.imm = {4'b0, insn[7:0]};
			snd.is_imm = 1'b1;
			snd.shift_imm = {insn[11:8], 1'b0}; // rotate is doubled
			snd.ror = 1'b1;
		end else begin
			snd = arm_decode_pkg::snd_reg_form(insn);
			if (data_shift_by_reg_if_reg) begin
				snd.shift_by_reg = 1'b1;
				snd.shift_imm = '0;
				snd.imm = {8'b0, insn[11:8]}; // rs
			end
		end
	end

	// pc in a register-shifted operand
	assign snd_undefined = !data_is_imm && data_shift_by_reg_if_reg
		&& (insn[11:8] == arm_decode_pkg::r15 || insn[3:0] == arm_decode_pkg::r15);

endmodule

// File: decode_ldst.sv
`timescale 1ns/1ps

module decode_ldst (
	input  arm_decode_pkg::word        insn,
	output arm_decode_pkg::ldst_decode ldst_single,
	                                   ldst_misc,
	                                   ldst_multiple,
	output logic                       ldst_single_is_imm,
	                                   ldst_misc_off_is_reg,
	output arm_decode_pkg::reg_num     ldst_misc_off_reg,
	output logic [7:0]                 ldst_misc_off_imm,
	output logic                       ldst_mult_restore_spsr,
	output arm_decode_pkg::data_decode data_ldst
);

	logic p_bit, u_bit, b_bit, w_bit, l_bit;

	assign p_bit = insn[24];
	assign u_bit = insn[23];
	assign b_bit = insn[22]; // also s on ldm/stm, i on misc
	assign w_bit = insn[21];
	assign l_bit = insn[20];

	always_comb begin
		ldst_single = '0;
		ldst_single.load = l_bit;
		ldst_single.writeback = !p_bit || w_bit; // post-index always updates
		ldst_single.pre_index = p_bit;
		ldst_single.increment = u_bit;
		ldst_single.size = b_bit ? 2'b00 : 2'b10;
		ldst_single.user_mode = !p_bit && w_bit; // ldrt strt
	end

	assign ldst_single_is_imm = !insn[25];

	always_comb begin
		ldst_misc = '0;
		ldst_misc.load = l_bit;
		ldst_misc.writeback = !p_bit || w_bit;
		ldst_misc.pre_index = p_bit;
		ldst_misc.increment = u_bit;
		ldst_misc.size = insn[5] ? 2'b01 : 2'b00;
		ldst_misc.sign_extend = insn[6];
	end

	assign ldst_misc_off_is_reg = !b_bit;
	assign ldst_misc_off_reg = insn[3:0];
	assign ldst_misc_off_imm = {insn[11:8], insn[3:0]};

	always_comb begin
		ldst_multiple = '0;
		ldst_multiple.load = l_bit;
		ldst_multiple.writeback = w_bit;
		ldst_multiple.pre_index = p_bit;
		ldst_multiple.increment = u_bit;
		ldst_multiple.size = 2'b10;
		ldst_multiple.user_mode = b_bit && !(l_bit && insn[15]); // user bank transfer
		ldst_multiple.reg_list = insn[15:0];
	end

	// ldm with s and pc in the list returns from exception
	assign ldst_mult_restore_spsr = b_bit && l_bit && insn[15];

	always_comb begin
		data_ldst.op = u_bit ? arm_decode_pkg::alu_add : arm_decode_pkg::alu_sub;
		data_ldst.rd = insn[15:12];
		data_ldst.rn = insn[19:16];
		data_ldst.uses_rn = 1'b1;
	end

endmodule

// File: decode_misc.sv
`timescale 1ns/1ps

module decode_misc (
	input  arm_decode_pkg::word          insn,
	output logic                         branch_link,
	                                     mul_update_flags,
	output arm_decode_pkg::reg_num       mul_rd,
	                                     mul_rs,
	                                     mul_rm,
	output arm_decode_pkg::coproc_decode coproc_ctrl,
	output logic                         coproc_writeback,
	                                     coproc_update_flags,
	output arm_decode_pkg::reg_num       coproc_rd,
	output logic                         msr_spsr,
	                                     msr_is_imm,
	                                     mrs_spsr,
	output arm_decode_pkg::reg_num       mrs_rd,
	output arm_decode_pkg::msr_mask      msr_fields
);

	logic mrc_to_pc;

	assign branch_link = insn[24];

	assign mul_update_flags = insn[20];
	assign mul_rd = insn[19:16];
	assign mul_rs = insn[11:8];
	assign mul_rm = insn[3:0];

	assign coproc_ctrl.load = insn[20]; // mrc
	assign coproc_ctrl.cp_num = insn[11:8];
	assign coproc_rd = insn[15:12];

	// mrc to r15 lands in nzcv
	assign mrc_to_pc = coproc_ctrl.load && coproc_rd == arm_decode_pkg::r15;
	assign coproc_writeback = coproc_ctrl.load && !mrc_to_pc;
	assign coproc_update_flags = mrc_to_pc;

	assign msr_spsr = insn[22];
	assign msr_is_imm = insn[25];
	assign msr_fields = insn[19:16]; // c x s f
	assign mrs_spsr = insn[22];
	assign mrs_rd = insn[15:12];

endmodule

// File: decode_mux.sv
`timescale 1ns/1ps

module decode_mux (
	input  arm_decode_pkg::word          insn,
	input  logic                         cond_execute,
	                                     cond_undefined,
	                                     explicit_cond,
	input  logic                         branch_link,
	input  arm_decode_pkg::data_decode   data,
	input  arm_decode_pkg::snd_decode    snd,
	input  logic                         snd_undefined,
	                                     data_writeback,
	                                     data_conditional,
	                                     data_update_flags,
	                                     data_restore_spsr,
	                                     data_is_imm,
	                                     data_shift_by_reg_if_reg,
	input  arm_decode_pkg::ldst_decode   ldst_single,
	                                     ldst_misc,
	                                     ldst_multiple,
	input  logic                         ldst_single_is_imm,
	                                     ldst_misc_off_is_reg,
	input  arm_decode_pkg::reg_num       ldst_misc_off_reg,
	input  logic [7:0]                   ldst_misc_off_imm,
	input  logic                         ldst_mult_restore_spsr,
	input  arm_decode_pkg::data_decode   data_ldst,
	input  logic                         mul_update_flags,
	input  arm_decode_pkg::reg_num       mul_rd,
	                                     mul_rs,
	                                     mul_rm,
	input  arm_decode_pkg::coproc_decode coproc_ctrl,
	input  logic                         coproc_writeback,
	                                     coproc_update_flags,
	input  arm_decode_pkg::reg_num       coproc_rd,
	input  logic                         msr_spsr,
	                                     msr_is_imm,
	                                     mrs_spsr,
	input  arm_decode_pkg::reg_num       mrs_rd,
	input  arm_decode_pkg::msr_mask      msr_fields,
	output arm_decode_pkg::decoded_insn  pkt
);

	logic is_b, is_mul, is_alu, is_single, is_misc, is_mult, is_cp, is_mrs, is_msr;
	logic misc_ok;

	assign is_b = arm_decode_pkg::grp_match(insn, arm_decode_pkg::grp_b);
	assign is_mul = arm_decode_pkg::grp_match(insn, arm_decode_pkg::grp_mul);
	assign is_single = arm_decode_pkg::grp_match(insn, arm_decode_pkg::grp_ldst_single);
	assign is_misc = arm_decode_pkg::grp_match(insn, arm_decode_pkg::grp_ldst_misc);
	assign is_mult = arm_decode_pkg::grp_match(insn, arm_decode_pkg::grp_ldst_mult);
	assign is_cp = arm_decode_pkg::grp_match(insn, arm_decode_pkg::grp_cp);
	assign is_mrs = arm_decode_pkg::grp_match(insn, arm_decode_pkg::grp_mrs);
	assign is_msr = arm_decode_pkg::grp_match(insn, arm_decode_pkg::grp_msr);

	// misc ldst and psr transfers live inside the alu space
	assign is_alu = arm_decode_pkg::grp_match(insn, arm_decode_pkg::grp_alu)
		&& !is_misc && !is_mrs && !is_msr;

	// ldrh ldrsb ldrsh strh
	assign misc_ok = {insn[20], insn[6:5]} inside {3'b101, 3'b110, 3'b111, 3'b001};

	always_comb begin
		pkt = '0;
		pkt.insn = insn;
		pkt.execute = cond_execute;
		pkt.undefined = cond_undefined;
		pkt.conditional = explicit_cond;

		// branch order sets the group priority
		if (is_b) begin
			pkt.branch = 1'b1;
			if (branch_link) begin
				pkt.data.op = arm_decode_pkg::alu_sub; // lr = pc - 4
				pkt.data.rd = arm_decode_pkg::r14;
				pkt.data.rn = arm_decode_pkg::r15;
				pkt.data.uses_rn = 1'b1;
				pkt.snd.imm = 12'd4;
				pkt.snd.is_imm = 1'b1;
				pkt.writeback = 1'b1;
			end
		end else if (is_mul) begin
			pkt.mul = 1'b1;
			pkt.data.op = insn[21] ? arm_decode_pkg::alu_add : arm_decode_pkg::alu_mov;
			pkt.data.rd = mul_rd;
			pkt.data.rn = insn[15:12]; // accumulator
			pkt.data.uses_rn = insn[21];
			pkt.snd.r = mul_rm;
			pkt.snd.imm = {8'b0, mul_rs};
			pkt.snd.shift_by_reg = 1'b1;
			pkt.writeback = 1'b1;
			pkt.update_flags = mul_update_flags;
		end else if (is_alu) begin
			pkt.data = data;
			pkt.snd = snd;
			pkt.snd.is_imm = data_is_imm;
			pkt.snd.shift_by_reg = !data_is_imm && data_shift_by_reg_if_reg;
			pkt.writeback = data_writeback;
			pkt.update_flags = data_update_flags;
			pkt.restore_spsr = data_restore_spsr;
			pkt.undefined = pkt.undefined || snd_undefined;
			pkt.conditional = pkt.conditional || data_conditional;
		end else if (is_single) begin
			pkt.ldst_op = 1'b1;
			pkt.ldst = ldst_single;
			pkt.ldst_addr = ldst_single;
			if (ldst_single_is_imm) begin
				pkt.snd.imm = insn[11:0];
				pkt.snd.is_imm = 1'b1;
			end else begin
				pkt.snd = arm_decode_pkg::snd_reg_form(insn);
				pkt.undefined = pkt.undefined || insn[4]; // media space
			end
		end else if (is_misc) begin
			pkt.ldst_op = 1'b1;
			if (misc_ok) begin
				pkt.ldst = ldst_misc;
				pkt.ldst_addr = ldst_misc;
				pkt.snd.r = ldst_misc_off_reg;
				pkt.snd.imm = {4'b0, ldst_misc_off_imm};
				pkt.snd.is_imm = !ldst_misc_off_is_reg;
			end else begin
				pkt.undefined = 1'b1; // swp and long multiply end up here
			end
		end else if (is_mult) begin
			pkt.ldst_op = 1'b1;
			pkt.ldst = ldst_multiple;
			pkt.ldst_addr = ldst_multiple;
			pkt.snd.imm = 12'd4; // word stride
			pkt.snd.is_imm = 1'b1;
			pkt.restore_spsr = ldst_mult_restore_spsr;
		end else if (is_cp) begin
			pkt.coproc = 1'b1;
			pkt.writeback = coproc_writeback;
			pkt.update_flags = coproc_update_flags;
			pkt.data.op = arm_decode_pkg::alu_mov;
			pkt.data.rd = coproc_rd;
			pkt.data.rn = coproc_rd;
			pkt.data.uses_rn = !coproc_ctrl.load; // mcr reads rd
		end else if (is_mrs) begin
			pkt.data.op = arm_decode_pkg::alu_mov;
			pkt.data.rd = mrs_rd;
			pkt.spsr = mrs_spsr;
			pkt.writeback = 1'b1;
			pkt.conditional = 1'b1;
		end else if (is_msr) begin
			pkt.snd = snd;
			pkt.snd.is_imm = msr_is_imm;
			pkt.snd.shift_by_reg = 1'b0;
			pkt.spsr = msr_spsr;
			pkt.psr_write = msr_fields != '0; // empty mask is a no-op
			pkt.conditional = 1'b1;
		end else begin
			pkt.undefined = 1'b1;
		end

		if (pkt.ldst_op) begin
			pkt.data = data_ldst;
			pkt.writeback = pkt.ldst.writeback || pkt.ldst.load;
		end

		if (pkt.undefined) begin
			pkt = '0;
			pkt.insn = insn;
			pkt.undefined = 1'b1;
		end
	end

	// exactly one unit claims a defined instruction
	always_comb begin
		assert ($onehot0({pkt.branch, pkt.ldst_op, pkt.mul, pkt.coproc}))
			else $error("decode_mux: more than one unit selected for %h", insn);
	end

endmodule

// File: decode_stage.sv
`timescale 1ns/1ps

module decode_stage #(
	parameter int FIFO_DEPTH = 4,
	parameter int EXEC_CREDITS = 2
) (
	input  logic                        clk,
	input  logic                        rst_n,
	input  logic                        in_valid,
	input  arm_decode_pkg::word         in_insn,
	input  arm_decode_pkg::psr_flags    in_flags,
	output logic                        fetch_credit,
	output logic                        out_valid,
	output arm_decode_pkg::decoded_insn out_pkt,
	input  logic                        exec_credit
);

	localparam int PTR_W = FIFO_DEPTH > 1 ? $clog2(FIFO_DEPTH) : 1;
	localparam int CNT_W = $clog2(FIFO_DEPTH + 1);
	localparam int CRD_W = $clog2(EXEC_CREDITS + 1);

	arm_decode_pkg::word q_insn [FIFO_DEPTH];
	arm_decode_pkg::psr_flags q_flags [FIFO_DEPTH];
	logic [PTR_W-1:0] wr_ptr, rd_ptr;
	logic [CNT_W-1:0] count;
	logic [CRD_W-1:0] credits;
	logic send;

	arm_decode_pkg::word insn;
	arm_decode_pkg::psr_flags flags;
	arm_decode_pkg::decoded_insn pkt;
	logic cond_execute, cond_undefined, explicit_cond, branch_link;
	arm_decode_pkg::data_decode data, data_ldst;
	arm_decode_pkg::snd_decode snd;
	logic snd_undefined, data_writeback, data_conditional, data_update_flags;
	logic data_restore_spsr, data_is_imm, data_shift_by_reg_if_reg;
	arm_decode_pkg::ldst_decode ldst_single, ldst_misc, ldst_multiple;
	logic ldst_single_is_imm, ldst_misc_off_is_reg, ldst_mult_restore_spsr;
	arm_decode_pkg::reg_num ldst_misc_off_reg, mul_rd, mul_rs, mul_rm, coproc_rd, mrs_rd;
	logic [7:0] ldst_misc_off_imm;
	logic mul_update_flags, coproc_writeback, coproc_update_flags;
	arm_decode_pkg::coproc_decode coproc_ctrl;
	logic msr_spsr, msr_is_imm, mrs_spsr;
	arm_decode_pkg::msr_mask msr_fields;

	assign insn = q_insn[rd_ptr]; // queue head
	assign flags = q_flags[rd_ptr];
	assign send = count != '0 && credits != '0;

	decode_cond cond_0 (.*);
	decode_data data_0 (.*);
	decode_ldst ldst_0 (.*);
	decode_misc misc_0 (.*);
	decode_mux mux_0 (.*);

	always_ff @(posedge clk) begin
		if (in_valid) begin
			q_insn[wr_ptr] <= in_insn;
			q_flags[wr_ptr] <= in_flags;
		end
		if (send)
			out_pkt <= pkt;
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
			credits <= CRD_W'(EXEC_CREDITS);
			out_valid <= 1'b0;
			fetch_credit <= 1'b0;
		end else begin
			if (in_valid)
				wr_ptr <= wr_ptr == PTR_W'(FIFO_DEPTH - 1) ? '0 : wr_ptr + 1'b1;
			if (send)
				rd_ptr <= rd_ptr == PTR_W'(FIFO_DEPTH - 1) ? '0 : rd_ptr + 1'b1;
			count <= count + CNT_W'(in_valid) - CNT_W'(send);
			credits <= credits + CRD_W'(exec_credit) - CRD_W'(send); // both may land together
			out_valid <= send;
			fetch_credit <= send; // slot freed as the head leaves
		end
	end

	assert property (@(posedge clk) disable iff (!rst_n) in_valid |-> count != CNT_W'(FIFO_DEPTH))
		else $error("decode_stage: fetch pushed into a full queue");

	assert property (@(posedge clk) disable iff (!rst_n) credits <= CRD_W'(EXEC_CREDITS))
		else $error("decode_stage: execute returned more credits than it was given");

	assert property (@(posedge clk) disable iff (!rst_n) out_valid |-> $past(credits) != '0)
		else $error("decode_stage: packet sent without an execute credit");

endmodule

// File: tb_decode_stage.sv
`timescale 1ns/1ps

module tb_decode_stage;

	localparam int FIFO_DEPTH = 4;
	localparam int EXEC_CREDITS = 2;

	logic clk = 1'b0;
	logic rst_n;
	logic in_valid;
	arm_decode_pkg::word in_insn;
	arm_decode_pkg::psr_flags in_flags;
	logic fetch_credit;
	logic out_valid;
	arm_decode_pkg::decoded_insn out_pkt;
	logic exec_credit = 1'b0;

	arm_decode_pkg::decoded_insn exp_q [$];
	arm_decode_pkg::decoded_insn exp_head;
	int sent = 0; // driver side
	int seq_errors = 0;
	int timeouts = 0;
	int last_accept = 0;
	int cycle = 0; // monitor side
	int pkts_seen = 0;
	int credits_back = 0;
	int fetch_pulses = 0;
	int outstanding = 0;
	int last_out_cyc = 0;
	int pkt_errors = 0;

	decode_stage #(.FIFO_DEPTH(FIFO_DEPTH), .EXEC_CREDITS(EXEC_CREDITS)) dut0 (.*);

	always #50 clk = ~clk;

	function automatic arm_decode_pkg::snd_decode shifter_operand(arm_decode_pkg::word i);
		arm_decode_pkg::snd_decode s;
		s = '0;
		if (i[25]) begin
			s.imm = {4'b0, i[7:0]};
			s.is_imm = 1'b1;
			s.shift_imm = {i[11:8], 1'b0};
			s.ror = 1'b1;
		end else begin
			s.r = i[3:0];
			s.shift_imm = i[11:7];
			s.shr = i[6] ^ i[5]; // lsr and asr
			s.ror = i[6];
			if (i[4]) begin
				s.shift_by_reg = 1'b1;
				s.shift_imm = '0;
				s.imm = {8'b0, i[11:8]};
			end
		end
		return s;
	endfunction

	function automatic logic in_group(arm_decode_pkg::word i, logic [23:0] bits, logic [23:0] mask);
		return (i[27:4] & mask) == bits;
	endfunction

	function automatic arm_decode_pkg::decoded_insn ref_decode(arm_decode_pkg::word i,
			arm_decode_pkg::psr_flags f);
		arm_decode_pkg::decoded_insn p;
		logic n, z, c, v, m_b, m_mul, m_alu, m_single, m_misc, m_mult, m_cp, m_mrs, m_msr;
		logic [3:0] op;
		logic is_cmp;
		p = '0;
		p.insn = i;
		{n, z, c, v} = f;
		case (i[31:28])
			4'h0: p.execute = z;
			4'h1: p.execute = !z;
			4'h2: p.execute = c;
			4'h3: p.execute = !c;
			4'h4: p.execute = n;
			4'h5: p.execute = !n;
			4'h6: p.execute = v;
			4'h7: p.execute = !v;
			4'h8: p.execute = c && !z;
			4'h9: p.execute = !c || z;
			4'ha: p.execute = n == v;
			4'hb: p.execute = n != v;
			4'hc: p.execute = !z && n == v;
			4'hd: p.execute = z || n != v;
			4'he: p.execute = 1'b1;
			default: p.undefined = 1'b1;
		endcase
		p.conditional = i[31:28] != 4'he;
		m_b = in_group(i, arm_decode_pkg::grp_b.bits, arm_decode_pkg::grp_b.mask);
		m_mul = in_group(i, arm_decode_pkg::grp_mul.bits, arm_decode_pkg::grp_mul.mask);
		m_single = in_group(i, arm_decode_pkg::grp_ldst_single.bits,
			arm_decode_pkg::grp_ldst_single.mask);
		m_misc = in_group(i, arm_decode_pkg::grp_ldst_misc.bits,
			arm_decode_pkg::grp_ldst_misc.mask);
		m_mult = in_group(i, arm_decode_pkg::grp_ldst_mult.bits,
			arm_decode_pkg::grp_ldst_mult.mask);
		m_cp = in_group(i, arm_decode_pkg::grp_cp.bits, arm_decode_pkg::grp_cp.mask);
		m_mrs = in_group(i, arm_decode_pkg::grp_mrs.bits, arm_decode_pkg::grp_mrs.mask);
		m_msr = in_group(i, arm_decode_pkg::grp_msr.bits, arm_decode_pkg::grp_msr.mask);
		m_alu = in_group(i, arm_decode_pkg::grp_alu.bits, arm_decode_pkg::grp_alu.mask)
			&& !m_misc && !m_mrs && !m_msr;
		op = i[24:21];
		is_cmp = op[3:2] == 2'b10;
		if (m_b) begin
			p.branch = 1'b1;
			if (i[24]) begin // link gets pc - 4
				p.data = '{op: arm_decode_pkg::alu_sub, rd: 4'd14, rn: 4'd15, uses_rn: 1'b1};
				p.snd.imm = 12'd4;
				p.snd.is_imm = 1'b1;
				p.writeback = 1'b1;
			end
		end else if (m_mul) begin
			p.mul = 1'b1;
			p.data = '{op: i[21] ? arm_decode_pkg::alu_add : arm_decode_pkg::alu_mov,
				rd: i[19:16], rn: i[15:12], uses_rn: i[21]};
			p.snd.r = i[3:0];
			p.snd.imm = {8'b0, i[11:8]};
			p.snd.shift_by_reg = 1'b1;
			p.writeback = 1'b1;
			p.update_flags = i[20];
		end else if (m_alu) begin
			p.data = '{op: op, rd: i[15:12], rn: i[19:16],
				uses_rn: op != arm_decode_pkg::alu_mov && op != arm_decode_pkg::alu_mvn};
			p.snd = shifter_operand(i);
			p.writeback = !is_cmp;
			p.update_flags = i[20] || is_cmp;
			p.restore_spsr = i[20] && !is_cmp && i[15:12] == 4'd15;
			if (!i[25] && i[4] && (i[11:8] == 4'd15 || i[3:0] == 4'd15))
				p.undefined = 1'b1;
			if (op == arm_decode_pkg::alu_adc || op == arm_decode_pkg::alu_sbc
					|| op == arm_decode_pkg::alu_rsc)
				p.conditional = 1'b1;
		end else if (m_single) begin
			p.ldst_op = 1'b1;
			p.ldst = '{load: i[20], writeback: !i[24] || i[21], pre_index: i[24],
				increment: i[23], size: i[22] ? 2'b00 : 2'b10, sign_extend: 1'b0,
				user_mode: !i[24] && i[21], reg_list: 16'h0};
			if (!i[25]) begin
				p.snd.imm = i[11:0];
				p.snd.is_imm = 1'b1;
			end else begin
				p.snd.r = i[3:0];
				p.snd.shift_imm = i[11:7];
				p.snd.shr = i[6] ^ i[5];
				p.snd.ror = i[6];
				if (i[4])
					p.undefined = 1'b1;
			end
		end else if (m_misc) begin
			p.ldst_op = 1'b1;
			// only ldrh, ldrsb, ldrsh and strh
			if ((i[20] && (i[6] || i[5])) || (!i[20] && !i[6] && i[5])) begin
				p.ldst = '{load: i[20], writeback: !i[24] || i[21], pre_index: i[24],
					increment: i[23], size: i[5] ? 2'b01 : 2'b00, sign_extend: i[6],
					user_mode: 1'b0, reg_list: 16'h0};
				p.snd.r = i[3:0];
				p.snd.imm = {4'b0, i[11:8], i[3:0]};
				p.snd.is_imm = i[22];
			end else begin
				p.undefined = 1'b1;
			end
		end else if (m_mult) begin
			p.ldst_op = 1'b1;
			p.ldst = '{load: i[20], writeback: i[21], pre_index: i[24], increment: i[23],
				size: 2'b10, sign_extend: 1'b0, user_mode: i[22] && !(i[20] && i[15]),
				reg_list: i[15:0]};
			p.snd.imm = 12'd4;
			p.snd.is_imm = 1'b1;
			p.restore_spsr = i[22] && i[20] && i[15];
		end else if (m_cp) begin
			p.coproc = 1'b1;
			p.writeback = i[20] && i[15:12] != 4'd15;
			p.update_flags = i[20] && i[15:12] == 4'd15;
			p.data = '{op: arm_decode_pkg::alu_mov, rd: i[15:12], rn: i[15:12], uses_rn: !i[20]};
		end else if (m_mrs) begin
			p.data.op = arm_decode_pkg::alu_mov;
			p.data.rd = i[15:12];
			p.spsr = i[22];
			p.writeback = 1'b1;
			p.conditional = 1'b1;
		end else if (m_msr) begin
			p.snd = shifter_operand(i);
			p.snd.shift_by_reg = 1'b0;
			p.spsr = i[22];
			p.psr_write = i[19:16] != 4'h0;
			p.conditional = 1'b1;
		end else begin
			p.undefined = 1'b1;
		end
		if (p.ldst_op) begin
			p.ldst_addr = p.ldst;
			p.data = '{op: i[23] ? arm_decode_pkg::alu_add : arm_decode_pkg::alu_sub,
				rd: i[15:12], rn: i[19:16], uses_rn: 1'b1};
			p.writeback = p.ldst.writeback || p.ldst.load;
		end
		if (p.undefined) begin
			p = '0;
			p.insn = i;
			p.undefined = 1'b1;
		end
		return p;
	endfunction

	task automatic compare_field(input string name, input logic [31:0] e, input logic [31:0] a,
			inout int errs);
		if (e !== a) begin
			$display("mismatch at %0t: out_pkt.%s expected %h actual %h", $time, name, e, a);
			errs++;
		end
	endtask

	task automatic check_pkt(input arm_decode_pkg::decoded_insn e,
			input arm_decode_pkg::decoded_insn a, inout int errs);
		compare_field("insn", e.insn, a.insn, errs);
		compare_field("data", 32'(e.data), 32'(a.data), errs);
		compare_field("snd", 32'(e.snd), 32'(a.snd), errs);
		compare_field("ldst", 32'(e.ldst), 32'(a.ldst), errs);
		compare_field("ldst_addr", 32'(e.ldst_addr), 32'(a.ldst_addr), errs);
		compare_field("execute", 32'(e.execute), 32'(a.execute), errs);
		compare_field("undefined", 32'(e.undefined), 32'(a.undefined), errs);
		compare_field("conditional", 32'(e.conditional), 32'(a.conditional), errs);
		compare_field("writeback", 32'(e.writeback), 32'(a.writeback), errs);
		compare_field("update_flags", 32'(e.update_flags), 32'(a.update_flags), errs);
		compare_field("branch", 32'(e.branch), 32'(a.branch), errs);
		compare_field("ldst_op", 32'(e.ldst_op), 32'(a.ldst_op), errs);
		compare_field("mul", 32'(e.mul), 32'(a.mul), errs);
		compare_field("coproc", 32'(e.coproc), 32'(a.coproc), errs);
		compare_field("spsr", 32'(e.spsr), 32'(a.spsr), errs);
		compare_field("psr_write", 32'(e.psr_write), 32'(a.psr_write), errs);
		compare_field("restore_spsr", 32'(e.restore_spsr), 32'(a.restore_spsr), errs);
	endtask

	task automatic check_count(input string name, input int e, input int a, inout int errs);
		if (e != a) begin
			$display("mismatch at %0t: %s expected %0d actual %0d", $time, name, e, a);
			errs++;
		end
	endtask

	// compare process, sampled before the edge updates anything
	always @(posedge clk) begin
		if (rst_n) begin
			cycle++;
			if (out_valid) begin
				if (exp_q.size() == 0) begin
					$display("packet at %0t with no instruction outstanding", $time);
					pkt_errors++;
				end else begin
					exp_head = exp_q.pop_front();
					check_pkt(exp_head, out_pkt, pkt_errors);
				end
				pkts_seen++;
				last_out_cyc = cycle;
			end
			if (exec_credit)
				credits_back++;
			if (fetch_credit)
				fetch_pulses++;
			outstanding = pkts_seen - credits_back;
			if (outstanding > EXEC_CREDITS) begin
				$display("more than %0d packets unreturned at %0t", EXEC_CREDITS, $time);
				pkt_errors++;
			end
		end
	end

	// execute model, holds credits back at random
	always @(negedge clk) begin
		if (!rst_n)
			exec_credit = 1'b0;
		else
			exec_credit = outstanding > 0 && $urandom_range(2) == 0;
	end

	task automatic send_insn(input arm_decode_pkg::word i, input arm_decode_pkg::psr_flags f);
		int t;
		t = 0;
		@(negedge clk);
		while (timeouts == 0 && FIFO_DEPTH - (sent - fetch_pulses) <= 0) begin
			in_valid = 1'b0;
			@(negedge clk);
			t++;
			if (t > 1000) begin
				$display("timeout waiting for a fetch credit");
				timeouts++;
			end
		end
		if (timeouts != 0) begin
			in_valid = 1'b0;
		end else begin
			in_valid = 1'b1;
			in_insn = i;
			in_flags = f;
			exp_q.push_back(ref_decode(i, f));
			sent++;
			last_accept = cycle + 1; // taken at the coming edge
		end
	endtask

	task automatic wait_drain();
		int t;
		t = 0;
		@(negedge clk);
		in_valid = 1'b0;
		while (timeouts == 0 && (fetch_pulses < sent || outstanding != 0)) begin
			@(negedge clk);
			t++;
			if (t > 2000) begin
				$display("timeout waiting for the decode stage to drain");
				timeouts++;
			end
		end
	endtask

	function automatic arm_decode_pkg::word make_insn(int kind);
		logic [31:0] r;
		logic [3:0] cond;
		r = $urandom;
		cond = $urandom_range(1) == 0 ? 4'he : 4'($urandom);
		case (kind)
			0: return {cond, 3'b101, r[24:0]};
			1: return {cond, 3'b001, r[24:0]};
			2: return {cond, 3'b000, r[24:5], 1'b0, r[3:0]};
			3: return {cond, 3'b000, r[24:8], 1'b0, r[6:5], 1'b1, r[3:0]};
			4: return {cond, 2'b01, r[25:0]};
			5: return {cond, 3'b000, r[24:8], 1'b1, r[6:5], 1'b1, r[3:0]};
			6: return {cond, 3'b100, r[24:0]};
			7: return {cond, 6'b000000, r[21:8], 4'b1001, r[3:0]};
			8: return {cond, 4'b1110, r[23:5], 1'b1, r[3:0]};
			9: return {cond, 5'b00010, r[22], 2'b00, 4'hf, r[15:12], 12'h000};
			10: return {cond, 2'b00, r[25], 2'b10, r[22], 2'b10, r[19:16], 4'hf, r[11:0]};
			default: return r;
		endcase
	endfunction

	arm_decode_pkg::word directed [15] = '{
		32'heb000010, 32'h1b000003, 32'he1b0f002, 32'he3510005, 32'he1a00211,
		32'he1d100b2, 32'he1d100d2, 32'he1c100f0, 32'he1012092, 32'hef000000,
		32'he8d18001, 32'he0020391, 32'he0234192, 32'hee110f10, 32'he129f001
	};

	initial begin
		void'($urandom(32'h7777));
		rst_n = 1'b0;
		in_valid = 1'b0;
		in_insn = '0;
		in_flags = '0;
		repeat (10) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;
		check_count("out_valid after reset", 0, int'(out_valid), seq_errors);
		check_count("fetch_credit after reset", 0, int'(fetch_credit), seq_errors);
		foreach (directed[k])
			send_insn(directed[k], 4'($urandom));
		send_insn(32'he10f0000, 4'h0); // mrs
		for (int k = 0; k < 600; k++)
			send_insn(make_insn($urandom_range(11)), 4'($urandom));
		wait_drain();
		// lone instruction into an empty queue with full credits
		send_insn(32'he0810002, 4'h0);
		wait_drain();
		check_count("latency", 1, last_out_cyc - 1 - last_accept, seq_errors);
		check_count("packets", sent, pkts_seen, seq_errors);
		check_count("fetch_credit pulses", sent, fetch_pulses, seq_errors);
		$display("errors: packet %0d, sequence %0d, timeout %0d",
			pkt_errors, seq_errors, timeouts);
		if (pkt_errors == 0 && seq_errors == 0 && timeouts == 0)
			$display("STATUS: PASS");
		else
			$display("STATUS: FAIL");
		$finish;
	end

endmodule

// File: arm_decode.f
arm_decode_pkg.sv
decode_cond.sv
decode_data.sv
decode_ldst.sv
decode_misc.sv
decode_mux.sv
decode_stage.sv
tb_decode_stage.sv

// File: run_sim.sh
#!/bin/sh
# compile and run the decode stage testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f arm_decode.f --top-module tb_decode_stage -o sim_decode
if [ $? -ne 0 ]; then
	echo "verilator compile failed"
	exit 1
fi

out=$(./obj_dir/sim_decode)
rc=$?
echo "$out"
if [ $rc -ne 0 ]; then
	echo "simulation exited with status $rc"
	exit 1
fi

if echo "$out" | grep -q "STATUS: PASS"; then
	exit 0
fi
exit 1
